// ==== hdl/soc_bus_pkg.sv ====
package soc_bus_pkg;

   // native bus request, a read when wstrb is all zero
   typedef struct packed {
      logic        avalid;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } iob_req_t;

   // native bus response
   typedef struct packed {
      logic [31:0] rdata;
      logic        rvalid;
      logic        ready;
   } iob_resp_t;

   // external memory port, strobe held until acknowledge
   typedef struct packed {
      logic        en;
      logic        we;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
   } ext_req_t;

   // timer register word offsets
   localparam logic [1:0] TMR_CTRL = 2'd0;
   localparam logic [1:0] TMR_CMP  = 2'd1;
   localparam logic [1:0] TMR_CNT  = 2'd2;

endpackage

// ==== hdl/iob_split.sv ====
`timescale 1ns/1ps

module iob_split import soc_bus_pkg::*; #(
   parameter int N_SLAVES = 2,
   parameter int P_SLAVES = 15
) (
   input  logic      clk_i,
   input  logic      reset_i,
   input  iob_req_t  m_req_i,
   output iob_resp_t m_resp_o,
   output iob_req_t  s_req_o [N_SLAVES],
   input  iob_resp_t s_resp_i [N_SLAVES]
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] sel_q;
   logic             pending;
   logic             resp_ret;
   logic             free;
   logic             accept;

   // slave select taken from the top address bits of this level
   assign sel = m_req_i.addr[P_SLAVES -: SEL_W];

   // response of the outstanding read comes back this cycle
   assign resp_ret = pending && s_resp_i[sel_q].rvalid;
   assign free     = !pending || resp_ret;

   always_comb begin
      m_resp_o.ready  = free && s_resp_i[sel].ready;
      m_resp_o.rvalid = resp_ret;
      m_resp_o.rdata  = s_resp_i[sel_q].rdata;
   end

   // forward in the same cycle, avalid only to the chosen slave
   always_comb begin
      for (int k = 0; k < N_SLAVES; k++) begin
         s_req_o[k]        = m_req_i;
         s_req_o[k].avalid = m_req_i.avalid && free && (sel == SEL_W'(k));
      end
   end

   assign accept = m_req_i.avalid && m_resp_o.ready;

   // remember who owes us read data
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pending <= 1'b0;
         sel_q   <= '0;
      end else if (accept && (m_req_i.wstrb == 4'b0000)) begin
         pending <= 1'b1;
         sel_q   <= sel;
      end else if (resp_ret) begin
         pending <= 1'b0;
      end
   end

endmodule

// ==== hdl/int_mem.sv ====
`timescale 1ns/1ps

module int_mem import soc_bus_pkg::*; #(
   parameter int SRAM_ADDR_W = 8
) (
   input  logic      clk_i,
   input  logic      reset_i,
   input  iob_req_t  req_i,
   output iob_resp_t resp_o
);

   logic [31:0]            mem [2**SRAM_ADDR_W];
   logic [SRAM_ADDR_W-1:0] word_addr;
   logic                   wr_en;
   logic                   rd_en;
   logic [31:0]            rdata_q;
   logic                   rvalid_q;

   // byte address in, word index out
   assign word_addr = req_i.addr[SRAM_ADDR_W+1:2];

   // ready never drops, so avalid alone means accepted
   assign wr_en = req_i.avalid && (req_i.wstrb != 4'b0000);
   assign rd_en = req_i.avalid && (req_i.wstrb == 4'b0000);

   // storage and read data path
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         for (int b = 0; b < 4; b++) begin
            if (req_i.wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
      if (rd_en) begin
         rdata_q <= mem[word_addr];
      end
   end

   // one-cycle read response
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_comb begin
      resp_o.ready  = 1'b1;
      resp_o.rvalid = rvalid_q;
      resp_o.rdata  = rdata_q;
   end

endmodule

// ==== hdl/ext_mem_bridge.sv ====
`timescale 1ns/1ps

module ext_mem_bridge import soc_bus_pkg::*; #(
   parameter int ADDR_W = 16
) (
   input  logic        clk_i,
   input  logic        reset_i,
   input  iob_req_t    req_i,
   output iob_resp_t   resp_o,
   output ext_req_t    ext_o,
   input  logic        ext_ack_i,
   input  logic [31:0] ext_rdata_i
);

   typedef enum logic {IDLE, BUSY} state_t;

   state_t      state;
   logic        accept;
   logic        we_q;
   logic [31:0] addr_q;
   logic [31:0] wdata_q;
   logic [3:0]  wstrb_q;
   logic [31:0] rdata_q;
   logic        rvalid_q;

   assign accept = req_i.avalid && (state == IDLE);

   // controller, busy from accept until the acknowledge
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state    <= IDLE;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= 1'b0;
         if (state == IDLE && accept) begin
            state <= BUSY;
         end else if (state == BUSY && ext_ack_i) begin
            state    <= IDLE;
            rvalid_q <= !we_q;
         end
      end
   end

   // request capture, dbus select bit cleared on the way out
   always_ff @(posedge clk_i) begin
      if (accept) begin
         we_q    <= (req_i.wstrb != 4'b0000);
         addr_q  <= 32'(req_i.addr[ADDR_W-2:0]);
         wdata_q <= req_i.wdata;
         wstrb_q <= req_i.wstrb;
      end
      if (state == BUSY && ext_ack_i) begin
         rdata_q <= ext_rdata_i;
      end
   end

   always_comb begin
      ext_o.en      = (state == BUSY);
      ext_o.we      = we_q;
      ext_o.addr    = addr_q;
      ext_o.wdata   = wdata_q;
      ext_o.wstrb   = wstrb_q;
      resp_o.ready  = (state == IDLE);
      resp_o.rvalid = rvalid_q;
      resp_o.rdata  = rdata_q;
   end

endmodule

// ==== hdl/timer_periph.sv ====
`timescale 1ns/1ps

module timer_periph import soc_bus_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,
   input  iob_req_t  req_i,
   output iob_resp_t resp_o,
   output logic      irq_o
);

   logic [1:0]  offset;
   logic        wr_en;
   logic        rd_en;
   logic        enable;
   logic [31:0] cmp;
   logic [31:0] cnt;
   logic [31:0] rdata_q;
   logic        rvalid_q;

   // register select by word offset
   assign offset = req_i.addr[3:2];
   assign wr_en  = req_i.avalid && (req_i.wstrb != 4'b0000);
   assign rd_en  = req_i.avalid && (req_i.wstrb == 4'b0000);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable   <= 1'b0;
         cmp      <= '0;
         cnt      <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
         if (enable) begin
            cnt <= cnt + 32'd1;
         end
         // a ctrl write restarts the count
         if (wr_en && offset == TMR_CTRL) begin
            enable <= req_i.wdata[0];
            cnt    <= '0;
         end
         if (wr_en && offset == TMR_CMP) begin
            cmp <= req_i.wdata;
         end
      end
   end

   // read data path
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         case (offset)
            TMR_CTRL: rdata_q <= {31'b0, enable};
            TMR_CMP:  rdata_q <= cmp;
            TMR_CNT:  rdata_q <= cnt;
            default:  rdata_q <= '0;
         endcase
      end
   end

   // level interrupt, follows the enable
   assign irq_o = enable && (cnt >= cmp);

   always_comb begin
      resp_o.ready  = 1'b1;
      resp_o.rvalid = rvalid_q;
      resp_o.rdata  = rdata_q;
   end

endmodule

// ==== hdl/soc_sys.sv ====
`timescale 1ns/1ps

module soc_sys import soc_bus_pkg::*; #(
   parameter int ADDR_W      = 16,
   parameter int SRAM_ADDR_W = 8
) (
   input  logic        clk_i,
   input  logic        reset_i,
   input  iob_req_t    bus_req_i,
   output iob_resp_t   bus_resp_o,
   output ext_req_t    ext_o,
   input  logic        ext_ack_i,
   input  logic [31:0] ext_rdata_i,
   output logic        irq_o
);

   // slave 0 internal bus, slave 1 external memory
   iob_req_t  dbus_req  [2];
   iob_resp_t dbus_resp [2];
   // slave 0 sram, slave 1 timer
   iob_req_t  pbus_req  [2];
   iob_resp_t pbus_resp [2];

   iob_split #(
      .N_SLAVES(2),
      .P_SLAVES(ADDR_W-1)
   ) dbus_split (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .m_req_i (bus_req_i),
      .m_resp_o(bus_resp_o),
      .s_req_o (dbus_req),
      .s_resp_i(dbus_resp)
   );

   iob_split #(
      .N_SLAVES(2),
      .P_SLAVES(ADDR_W-2)
   ) pbus_split (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .m_req_i (dbus_req[0]),
      .m_resp_o(dbus_resp[0]),
      .s_req_o (pbus_req),
      .s_resp_i(pbus_resp)
   );

   int_mem #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) int_mem0 (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (pbus_req[0]),
      .resp_o (pbus_resp[0])
   );

   timer_periph timer0 (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .req_i  (pbus_req[1]),
      .resp_o (pbus_resp[1]),
      .irq_o  (irq_o)
   );

   ext_mem_bridge #(
      .ADDR_W(ADDR_W)
   ) ext_mem0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (dbus_req[1]),
      .resp_o     (dbus_resp[1]),
      .ext_o      (ext_o),
      .ext_ack_i  (ext_ack_i),
      .ext_rdata_i(ext_rdata_i)
   );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
   parameter real PERIOD_NS    = 8.0,
   parameter int  RESET_CYCLES = 3
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o   = 1'b0;
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      reset_o <= 1'b0;
   end

   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== bench/soc_sys_assert.sv ====
`timescale 1ns/1ps

module soc_sys_assert import soc_bus_pkg::*; (
   input logic      clk_i,
   input logic      reset_i,
   input iob_req_t  bus_req_i,
   input iob_resp_t bus_resp_i,
   input ext_req_t  ext_i,
   input logic      ext_ack_i,
   input logic      irq_i,
   input iob_req_t  int_req_i,
   input iob_resp_t int_resp_i,
   input iob_req_t  tmr_req_i,
   input iob_resp_t tmr_resp_i
);

   int   err_cnt = 0;
   logic rd_out;
   logic tmr_on;

   // one read outstanding at the top port
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_out <= 1'b0;
      end else if (bus_req_i.avalid && bus_resp_i.ready && bus_req_i.wstrb == 4'b0000) begin
         rd_out <= 1'b1;
      end else if (bus_resp_i.rvalid) begin
         rd_out <= 1'b0;
      end
   end

   // timer enable as last written through the ctrl register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         tmr_on <= 1'b0;
      end else if (tmr_req_i.avalid && tmr_resp_i.ready && tmr_req_i.wstrb != 4'b0000
                   && tmr_req_i.addr[3:2] == TMR_CTRL) begin
         tmr_on <= tmr_req_i.wdata[0];
      end
   end

   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      bus_resp_i.rvalid |-> rd_out)
      else begin
         err_cnt++;
         $error("rvalid without an accepted read");
      end

   a_en_held: assert property (@(posedge clk_i) disable iff (reset_i)
      ext_i.en && !ext_ack_i |=> ext_i.en)
      else begin
         err_cnt++;
         $error("ext en dropped before acknowledge");
      end

   a_irq_disabled: assert property (@(posedge clk_i) disable iff (reset_i)
      !tmr_on |-> !irq_i)
      else begin
         err_cnt++;
         $error("irq high while timer disabled");
      end

   // internal bus reads answer one cycle after accept
   a_int_lat: assert property (@(posedge clk_i) disable iff (reset_i)
      int_resp_i.rvalid == $past(int_req_i.avalid && int_resp_i.ready
                                 && int_req_i.wstrb == 4'b0000))
      else begin
         err_cnt++;
         $error("internal rvalid not one cycle after read");
      end

endmodule

bind soc_sys soc_sys_assert u_assert (
   .clk_i      (clk_i),
   .reset_i    (reset_i),
   .bus_req_i  (bus_req_i),
   .bus_resp_i (bus_resp_o),
   .ext_i      (ext_o),
   .ext_ack_i  (ext_ack_i),
   .irq_i      (irq_o),
   .int_req_i  (dbus_req[0]),
   .int_resp_i (dbus_resp[0]),
   .tmr_req_i  (pbus_req[1]),
   .tmr_resp_i (pbus_resp[1])
);

// ==== bench/soc_sys_tb.sv ====
`timescale 1ns/1ps

module soc_sys_tb import soc_bus_pkg::*; ;

   localparam int TMO = 200;

   logic        clk_i;
   logic        reset_i;
   iob_req_t    bus_req;
   iob_resp_t   bus_resp;
   ext_req_t    ext_o;
   logic        ext_ack_i;
   logic [31:0] ext_rdata_i;
   logic        irq_o;

   logic [31:0] sram_sh [256];
   logic [31:0] ext_mem [256];
   logic [31:0] ext_sh  [256];
   logic [31:0] m_addr;
   logic        m_busy;
   int          m_delay;
   int          ack_gap;
   int          rdy_early;
   logic        rdy_back;
   int          errors;
   int          tests;
   int          failed;
   int          err_at_start;

   clk_gen clk_gen0 (.clk_o(clk_i), .reset_o(reset_i));

   soc_sys #(.ADDR_W(16), .SRAM_ADDR_W(8)) dut_i (
      .clk_i(clk_i), .reset_i(reset_i), .bus_req_i(bus_req), .bus_resp_o(bus_resp),
      .ext_o(ext_o), .ext_ack_i(ext_ack_i), .ext_rdata_i(ext_rdata_i), .irq_o(irq_o)
   );

   function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                               logic [3:0] strb);
      logic [31:0] r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
      end
      return r;
   endfunction

   // external memory with a random acknowledge delay of 0 to 7 cycles
   always @(posedge clk_i) begin
      ext_ack_i <= 1'b0;
      if (reset_i) begin
         m_busy = 1'b0;
      end else if (ext_o.en && !ext_ack_i) begin
         if (!m_busy) begin
            m_busy  = 1'b1;
            m_delay = $urandom % 8;
            m_addr  = ext_o.addr;
         end
         if (m_delay == 0) begin
            ext_ack_i   <= 1'b1;
            ext_rdata_i <= ext_mem[ext_o.addr[9:2]];
            if (ext_o.we) begin
               ext_mem[ext_o.addr[9:2]] = merge_bytes(ext_mem[ext_o.addr[9:2]], ext_o.wdata,
                                                      ext_o.wstrb);
            end
            m_busy = 1'b0;
         end else begin
            m_delay--;
         end
      end
   end

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("sim failed");
      $finish;
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Fail %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk_i);
      while (!bus_resp.ready) begin
         if (n >= TMO) abort_run("ready");
         @(negedge clk_i);
         n++;
      end
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      @(posedge clk_i);
      bus_req <= '{avalid: 1'b1, addr: addr, wdata: data, wstrb: strb};
      wait_ready();
      @(posedge clk_i);
      bus_req.avalid <= 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      int n;
      int ack_at;
      n = 0;
      ack_at = -100;
      rdy_early = 0;
      @(posedge clk_i);
      bus_req <= '{avalid: 1'b1, addr: addr, wdata: 32'h0, wstrb: 4'h0};
      wait_ready();
      @(posedge clk_i);
      bus_req.avalid <= 1'b0;
      @(negedge clk_i);
      while (!bus_resp.rvalid) begin
         if (ext_ack_i) ack_at = n;
         // ready must stay low while the read is outstanding
         if (bus_resp.ready) rdy_early++;
         if (n >= TMO) abort_run("rvalid");
         @(negedge clk_i);
         n++;
      end
      ack_gap = n - ack_at;
      rdy_back = bus_resp.ready;
      data = bus_resp.rdata;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == err_at_start) begin
         $display("test %s ok", name);
      end else begin
         failed++;
         $display("test %s had %0d errors", name, errors - err_at_start);
      end
      err_at_start = errors;
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] d;
      logic [31:0] c0;
      logic [3:0]  s;
      int          idx;
      int          n;
      int          q [8];
      void'($urandom(32'h1c04_be92));
      bus_req     = '0;
      ext_ack_i   = 1'b0;
      ext_rdata_i = '0;
      errors       = 0;
      tests        = 0;
      failed       = 0;
      err_at_start = 0;
      for (int i = 0; i < 256; i++) begin
         ext_mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
         ext_sh[i]  = ext_mem[i];
      end
      n = 0;
      while (reset_i !== 1'b0) begin
         if (n >= TMO) abort_run("reset release");
         @(posedge clk_i);
         n++;
      end

      // sram, whole-word fill first, then partial writes
      for (int i = 0; i < 256; i++) begin
         sram_sh[i] = 32'hc3c3_0000 | i;
         bus_write(i << 2, sram_sh[i], 4'hf);
      end
      for (int i = 0; i < 20; i++) begin
         idx = $urandom % 256;
         d   = $urandom;
         s   = 4'($urandom % 15 + 1);
         sram_sh[idx] = merge_bytes(sram_sh[idx], d, s);
         bus_write(idx << 2, d, s);
         bus_read(idx << 2, rd);
         check_val("sram_rw", sram_sh[idx], rd);
      end
      end_test("sram_rw");

      // one read accepted per cycle
      for (int i = 0; i < 8; i++) begin
         q[i] = $urandom % 256;
         @(posedge clk_i);
         bus_req <= '{avalid: 1'b1, addr: q[i] << 2, wdata: 32'h0, wstrb: 4'h0};
         @(negedge clk_i);
         check_val("b2b_ready", 32'h1, {31'b0, bus_resp.ready});
         if (i > 0) begin
            check_val("b2b_rvalid", 32'h1, {31'b0, bus_resp.rvalid});
            check_val("b2b_data", sram_sh[q[i-1]], bus_resp.rdata);
         end
      end
      @(posedge clk_i);
      bus_req.avalid <= 1'b0;
      @(negedge clk_i);
      check_val("b2b_rvalid", 32'h1, {31'b0, bus_resp.rvalid});
      check_val("b2b_data", sram_sh[q[7]], bus_resp.rdata);
      end_test("sram_b2b");

      // external memory behind the bridge
      for (int i = 0; i < 12; i++) begin
         idx = $urandom % 256;
         d   = $urandom;
         s   = 4'($urandom % 15 + 1);
         ext_sh[idx] = merge_bytes(ext_sh[idx], d, s);
         bus_write(32'h8000 | (idx << 2), d, s);
         bus_read(32'h8000 | (idx << 2), rd);
         check_val("ext_data", ext_sh[idx], rd);
         check_val("ext_addr", idx << 2, m_addr);
         check_val("ext_ack_to_rvalid", 32'd1, ack_gap);
         check_val("ext_ready_low", 32'd0, rdy_early);
         check_val("ext_ready_back", 32'h1, {31'b0, rdy_back});
      end
      end_test("ext_mem");

      // same low bits, three different slaves
      bus_write(32'h0004, 32'h1111_aaaa, 4'hf);
      bus_write(32'h4004, 32'h2222_bbbb, 4'hf);
      bus_write(32'h8004, 32'h3333_cccc, 4'hf);
      sram_sh[1] = 32'h1111_aaaa;
      ext_sh[1]  = 32'h3333_cccc;
      bus_read(32'h0004, rd);
      check_val("decode_sram", 32'h1111_aaaa, rd);
      bus_read(32'h4004, rd);
      check_val("decode_timer", 32'h2222_bbbb, rd);
      bus_read(32'h8004, rd);
      check_val("decode_ext", 32'h3333_cccc, rd);
      end_test("decode");

      // timer compare, count and interrupt drop
      c0 = 32'd20;
      bus_write(32'h4000 | (TMR_CMP << 2), c0, 4'hf);
      bus_write(32'h4000 | (TMR_CTRL << 2), 32'h1, 4'hf);
      n = 0;
      @(negedge clk_i);
      while (!irq_o) begin
         if (n >= c0 + 10) abort_run("irq");
         @(negedge clk_i);
         n++;
      end
      bus_read(32'h4000 | (TMR_CNT << 2), c0);
      bus_read(32'h4000 | (TMR_CNT << 2), rd);
      if (rd < c0) begin
         $display("Fail timer_cnt expected at least %h actual %h", c0, rd);
         errors++;
      end
      @(posedge clk_i);
      bus_req <= '{avalid: 1'b1, addr: 32'h4000, wdata: 32'h0, wstrb: 4'hf};
      wait_ready();
      @(posedge clk_i);
      bus_req.avalid <= 1'b0;
      @(negedge clk_i);
      check_val("timer_irq_off", 32'h0, {31'b0, irq_o});
      end_test("timer");

      errors += dut_i.u_assert.err_cnt;
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== src.f ====
hdl/soc_bus_pkg.sv
hdl/iob_split.sv
hdl/int_mem.sv
hdl/ext_mem_bridge.sv
hdl/timer_periph.sv
hdl/soc_sys.sv
bench/clk_gen.sv
bench/soc_sys_assert.sv
bench/soc_sys_tb.sv

// ==== Makefile ====
# Verilator build and run of the soc_sys testbench

VERILATOR ?= verilator
TOP       ?= soc_sys_tb
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
